/* design/lbc_defs.svh */
`ifndef LBC_DEFS_SVH
`define LBC_DEFS_SVH

// Local bus address width, one word per address
`define LBC_AW 8

// Data word width
`define LBC_DW 32

// Posted write entries
`define LBC_WB_DEPTH 4

// Command strobe to completion, in cycles
`define LBC_BUS_LAT 4

// Words behind the bus engine
`define LBC_MEM_WORDS 256

`endif

/* design/lbc_pkg.sv */
`default_nettype none
`include "lbc_defs.svh"

package lbc_pkg;

  typedef enum logic [1:0] {
    IFETCH = 2'd0,
    DREAD  = 2'd1,
    DWRITE = 2'd2
  } lbc_kind_e;

  // Listed in arbitration priority order
  typedef enum logic [1:0] {
    SRC_EJ = 2'd0,
    SRC_I  = 2'd1,
    SRC_DR = 2'd2,
    SRC_DW = 2'd3   // Write buffer drain
  } lbc_src_e;

  typedef struct packed {
    lbc_kind_e          kind;
    logic               uc;
    logic [`LBC_AW-1:0] addr;
    logic [`LBC_DW-1:0] wdata;
  } cbus_req_t;

  typedef struct packed {
    logic               write;
    logic [`LBC_AW-1:0] addr;
    logic [`LBC_DW-1:0] wdata;
  } ej_req_t;

  typedef struct packed {
    logic [`LBC_AW-1:0] addr;
    logic [`LBC_DW-1:0] data;
  } wb_entry_t;

  typedef struct packed {
    lbc_src_e           src;
    logic               write;
    logic [`LBC_AW-1:0] addr;
    logic [`LBC_DW-1:0] data;
  } bus_cmd_t;

  typedef struct packed {
    lbc_src_e           src;
    logic [`LBC_AW-1:0] addr;
    logic [`LBC_DW-1:0] rdata;  // Echoes write data on writes
  } lbc_rsp_t;

endpackage

`default_nettype wire

/* design/lbc_write_buf.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lbc_defs.svh"

module lbc_write_buf
  import lbc_pkg::*;
(
  input  wire logic               SYSCLK,
  input  wire logic               arst_n,
  input  wire logic               wb_push,
  input  wire wb_entry_t          wb_wdata,
  input  wire logic               wb_pop,
  input  wire logic [`LBC_AW-1:0] hit_addr,
  output logic                    wb_valid,
  output wb_entry_t               wb_head,
  output logic                    wb_full,
  output logic                    wb_hit
);

  localparam int PW = (`LBC_WB_DEPTH > 1) ? $clog2(`LBC_WB_DEPTH) : 1;
  localparam int CW = $clog2(`LBC_WB_DEPTH + 1);
  localparam logic [CW-1:0] FULL_CNT  = CW'(`LBC_WB_DEPTH);
  localparam logic [PW-1:0] LAST_SLOT = PW'(`LBC_WB_DEPTH - 1);

  wb_entry_t ram [`LBC_WB_DEPTH];
  logic [PW-1:0] rd_ptr, wr_ptr;
  logic [CW-1:0] count;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == LAST_SLOT) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge SYSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wb_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (wb_pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (wb_push && !wb_pop)
        count <= count + 1'b1;
      else if (wb_pop && !wb_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge SYSCLK)
  begin
    if (wb_push)
      ram[wr_ptr] <= wb_wdata;
  end

  assign wb_valid = (count != '0);
  assign wb_head  = ram[rd_ptr];

  // Counts the write landing this cycle
  assign wb_full = (count == FULL_CNT) ||
                   ((count == FULL_CNT - 1'b1) && wb_push && !wb_pop);

  // Compare against occupied slots only, oldest first
  always_comb
  begin : hit_scan
    automatic int slot;
    wb_hit = 1'b0;
    slot   = int'(rd_ptr);
    for (int k = 0; k < `LBC_WB_DEPTH; k++)
    begin
      if ((k < int'(count)) && (ram[slot].addr == hit_addr))
        wb_hit = 1'b1;
      slot = (slot == `LBC_WB_DEPTH - 1) ? 0 : slot + 1;
    end
  end

  a_no_overflow: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    (wb_push && (count == FULL_CNT)) |-> wb_pop)
    else $error("Write buffer overflow, posted write while halt_w was high");

  a_no_underflow: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    wb_pop |-> wb_valid)
    else $error("Drain completed with write buffer empty");

endmodule

`default_nettype wire

/* design/lbc_bus_engine.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lbc_defs.svh"

module lbc_bus_engine
  import lbc_pkg::*;
(
  input  wire logic     SYSCLK,
  input  wire logic     arst_n,
  input  wire logic     cmd_valid,
  input  wire bus_cmd_t cmd,
  output logic          done_valid,
  output lbc_rsp_t      done
);

  localparam int CNTW = $clog2(`LBC_BUS_LAT + 1);
  localparam logic [CNTW-1:0] LAT_M1 = CNTW'(`LBC_BUS_LAT - 1);

  bus_cmd_t cur;
  logic busy;
  logic [CNTW-1:0] cnt;
  logic finish;
  logic [`LBC_DW-1:0] mem [`LBC_MEM_WORDS];

  initial
  begin
    for (int i = 0; i < `LBC_MEM_WORDS; i++)
      mem[i] = '0;
  end

  // Last busy cycle, done goes out on the next edge
  assign finish = busy && (cnt == CNTW'(1));

  always_ff @(posedge SYSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy       <= 1'b0;
      cnt        <= '0;
      done_valid <= 1'b0;
    end
    else
    begin
      done_valid <= finish;
      if (cmd_valid)
      begin
        busy <= 1'b1;
        cnt  <= LAT_M1;
      end
      else if (finish)
        busy <= 1'b0;
      else if (busy)
        cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge SYSCLK)
  begin
    if (cmd_valid)
      cur <= cmd;
    if (finish)
    begin
      done.src   <= cur.src;
      done.addr  <= cur.addr;
      done.rdata <= cur.write ? cur.data : mem[cur.addr];
    end
  end

  always @(posedge SYSCLK)
  begin
    if (finish && cur.write)
      mem[cur.addr] <= cur.data;
  end

  a_one_cmd: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    cmd_valid |-> !busy)
    else $error("Bus command while previous command still in progress");

endmodule

`default_nettype wire

/* design/lbc_cbus.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lbc_defs.svh"

module lbc_cbus
  import lbc_pkg::*;
(
  input  wire logic        SYSCLK,
  input  wire logic        arst_n,
  input  wire logic        cpu_valid,
  input  wire cbus_req_t   cpu_req,
  input  wire logic        ej_valid,
  input  wire ej_req_t     ej_req,
  input  wire logic        wb_valid,
  input  wire wb_entry_t   wb_head,
  input  wire logic        wb_hit,
  input  wire logic        done_valid,
  input  wire lbc_rsp_t    done,
  output logic             wb_push,
  output wb_entry_t        wb_wdata,
  output logic             wb_pop,
  output logic [`LBC_AW-1:0] hit_addr,
  output logic             cmd_valid,
  output bus_cmd_t         cmd,
  output logic             rsp_valid,
  output lbc_rsp_t         rsp
);

  logic busy;
  logic ej_pend, i_pend, dr_pend;
  ej_req_t ej_q;
  logic [`LBC_AW-1:0] i_addr, dr_addr;
  logic dr_uc;

  logic i_strobe, dr_strobe, dw_strobe;
  logic cand_valid;
  lbc_src_e cand_src;
  logic cand_write;
  logic [`LBC_AW-1:0] cand_addr;
  logic [`LBC_DW-1:0] cand_data;
  logic push_hit, cand_blocked;
  logic launch_cand, launch_drain;

  assign i_strobe  = cpu_valid && (cpu_req.kind == IFETCH);
  assign dr_strobe = cpu_valid && (cpu_req.kind == DREAD);
  assign dw_strobe = cpu_valid && (cpu_req.kind == DWRITE);

  // Highest priority pending request
  always_comb
  begin
    cand_valid = 1'b1;
    cand_write = 1'b0;
    cand_data  = '0;
    if (ej_pend)
    begin
      cand_src   = SRC_EJ;
      cand_addr  = ej_q.addr;
      cand_write = ej_q.write;
      cand_data  = ej_q.wdata;
    end
    else if (i_pend)
    begin
      cand_src  = SRC_I;
      cand_addr = i_addr;
    end
    else if (dr_pend)
    begin
      cand_src  = SRC_DR;
      cand_addr = dr_addr;
    end
    else
    begin
      cand_valid = 1'b0;
      cand_src   = SRC_DW;
      cand_addr  = wb_head.addr;
    end
  end

  assign hit_addr = cand_addr;

  // A write still on its way into the buffer counts as buffered
  assign push_hit = wb_push && (wb_wdata.addr == cand_addr);
  assign cand_blocked = wb_hit || push_hit ||
                        ((cand_src == SRC_DR) && dr_uc && (wb_valid || wb_push));

  // Blocked candidate implies buffered writes, so the drain always moves
  assign launch_cand  = !busy && cand_valid && !cand_blocked;
  assign launch_drain = !busy && !launch_cand && wb_valid;

  always_ff @(posedge SYSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy      <= 1'b0;
      cmd_valid <= 1'b0;
      ej_pend   <= 1'b0;
      i_pend    <= 1'b0;
      dr_pend   <= 1'b0;
      wb_push   <= 1'b0;
    end
    else
    begin
      cmd_valid <= launch_cand || launch_drain;
      if (launch_cand || launch_drain)
        busy <= 1'b1;
      else if (done_valid)
        busy <= 1'b0;
      ej_pend <= ej_valid  || (ej_pend && !(done_valid && done.src == SRC_EJ));
      i_pend  <= i_strobe  || (i_pend  && !(done_valid && done.src == SRC_I));
      dr_pend <= dr_strobe || (dr_pend && !(done_valid && done.src == SRC_DR));
      wb_push <= dw_strobe;
    end
  end

  always_ff @(posedge SYSCLK)
  begin
    if (ej_valid)
      ej_q <= ej_req;
    if (i_strobe)
      i_addr <= cpu_req.addr;
    if (dr_strobe)
    begin
      dr_addr <= cpu_req.addr;
      dr_uc   <= cpu_req.uc;
    end
    if (dw_strobe)
    begin
      wb_wdata.addr <= cpu_req.addr;
      wb_wdata.data <= cpu_req.wdata;
    end
    if (launch_cand)
      cmd <= '{src: cand_src, write: cand_write, addr: cand_addr, data: cand_data};
    else if (launch_drain)
      cmd <= '{src: SRC_DW, write: 1'b1, addr: wb_head.addr, data: wb_head.data};
  end

  // Drains retire silently
  assign rsp_valid = done_valid && (done.src != SRC_DW);
  assign rsp       = done;
  assign wb_pop    = done_valid && (done.src == SRC_DW);

  a_ej_single: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    ej_valid |-> !ej_pend)
    else $error("Debug request strobed while one is outstanding");

  a_i_single: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    i_strobe |-> !i_pend)
    else $error("Fetch strobed while one is outstanding");

  a_dr_single: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    dr_strobe |-> !dr_pend)
    else $error("Data read strobed while one is outstanding");

  // One command in flight until the bus side completes it
  a_cmd_idle: assert property (@(posedge SYSCLK) disable iff (!arst_n)
    cmd_valid |=> !cmd_valid until done_valid)
    else $error("Command issued while a transaction is in flight");

endmodule

`default_nettype wire

/* design/lbc_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lbc_defs.svh"

module lbc_top
  import lbc_pkg::*;
(
  input  wire logic      SYSCLK,
  input  wire logic      arst_n,
  input  wire logic      cpu_valid,
  input  wire cbus_req_t cpu_req,
  input  wire logic      ej_valid,
  input  wire ej_req_t   ej_req,
  output logic           rsp_valid,
  output lbc_rsp_t       rsp,
  output logic           halt_w
);

  logic wb_push, wb_pop;
  wb_entry_t wb_wdata, wb_head;
  logic wb_valid, wb_full, wb_hit;
  logic [`LBC_AW-1:0] hit_addr;
  logic cmd_valid, done_valid;
  bus_cmd_t cmd;
  lbc_rsp_t done;

  lbc_cbus lbc_cbus_i (
    .SYSCLK     (SYSCLK),
    .arst_n     (arst_n),
    .cpu_valid  (cpu_valid),
    .cpu_req    (cpu_req),
    .ej_valid   (ej_valid),
    .ej_req     (ej_req),
    .wb_valid   (wb_valid),
    .wb_head    (wb_head),
    .wb_hit     (wb_hit),
    .done_valid (done_valid),
    .done       (done),
    .wb_push    (wb_push),
    .wb_wdata   (wb_wdata),
    .wb_pop     (wb_pop),
    .hit_addr   (hit_addr),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

  lbc_write_buf lbc_write_buf_i (
    .SYSCLK   (SYSCLK),
    .arst_n   (arst_n),
    .wb_push  (wb_push),
    .wb_wdata (wb_wdata),
    .wb_pop   (wb_pop),
    .hit_addr (hit_addr),
    .wb_valid (wb_valid),
    .wb_head  (wb_head),
    .wb_full  (wb_full),
    .wb_hit   (wb_hit)
  );

  lbc_bus_engine lbc_bus_engine_i (
    .SYSCLK     (SYSCLK),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .done_valid (done_valid),
    .done       (done)
  );

  assign halt_w = wb_full;  // CPU holds off DWRITE while set

endmodule

`default_nettype wire

/* bench/lbc_checker.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lbc_defs.svh"

module lbc_checker
  import lbc_pkg::*;
(
  input wire logic     SYSCLK,
  input wire logic     arst_n,
  input wire logic     rsp_valid,
  input wire lbc_rsp_t rsp,
  input wire logic     halt_w
);

  // Expected responses, oldest first, all sources in one list
  string              e_name[$];
  lbc_src_e           e_src[$];
  logic [`LBC_AW-1:0] e_addr[$];
  logic [`LBC_DW-1:0] e_data[$];
  int passes = 0;
  int errors = 0;
  logic saw_full = 1'b0;  // Burst of 8 outruns a 4 deep buffer

  task automatic expect_rsp(input string name, input lbc_src_e src,
                            input logic [`LBC_AW-1:0] addr,
                            input logic [`LBC_DW-1:0] data);
    e_name.push_back(name);
    e_src.push_back(src);
    e_addr.push_back(addr);
    e_data.push_back(data);
  endtask

  function automatic int outstanding(input lbc_src_e src);
    int n = 0;
    for (int k = 0; k < e_src.size(); k++)
      if (e_src[k] == src)
        n++;
    return n;
  endfunction

  function automatic int remaining();
    return e_src.size();
  endfunction

  task automatic check_rsp(input lbc_rsp_t r);
    int idx = -1;
    for (int k = e_src.size() - 1; k >= 0; k--)
      if (e_src[k] == r.src)
        idx = k;  // Oldest entry of this source
    if (idx < 0)
    begin
      $display("Response from source %0d at address %02h with nothing expected",
               r.src, r.addr);
      errors++;
    end
    else
    begin
      if ((r.addr == e_addr[idx]) && (r.rdata == e_data[idx]))
      begin
        $display("PASS %s src %0d addr %02h data %08h", e_name[idx], r.src, r.addr, r.rdata);
        passes++;
      end
      else
      begin
        $display("ERR %s expected %02h:%08h actual %02h:%08h",
                 e_name[idx], e_addr[idx], e_data[idx], r.addr, r.rdata);
        errors++;
      end
      e_name.delete(idx);
      e_src.delete(idx);
      e_addr.delete(idx);
      e_data.delete(idx);
    end
  endtask

  always @(posedge SYSCLK)
  begin
    if (arst_n && rsp_valid)
      check_rsp(rsp);
    if (arst_n && halt_w)
      saw_full = 1'b1;
    if (!arst_n && halt_w)
    begin
      $display("Write buffer full flag high during reset");
      errors++;
    end
  end

  task automatic report_totals();
    for (int k = 0; k < e_src.size(); k++)
    begin
      $display("No response arrived for %s at address %02h", e_name[k], e_addr[k]);
      errors++;
    end
    if (!saw_full)
    begin
      $display("Write buffer full flag never rose during the write burst");
      errors++;
    end
    if (halt_w)
    begin
      $display("Write buffer full flag still high at the end of the run");
      errors++;
    end
    $display("Totals: %0d passed, %0d failed", passes, errors);
  endtask

endmodule

`default_nettype wire

/* bench/lbc_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lbc_defs.svh"

module lbc_tb
  import lbc_pkg::*;
();

  localparam int RST_CYCLES = 10;

  logic      SYSCLK;
  logic      arst_n;
  logic      cpu_valid;
  cbus_req_t cpu_req;
  logic      ej_valid;
  ej_req_t   ej_req;
  logic      rsp_valid;
  lbc_rsp_t  rsp;
  logic      halt_w;

  // Parsed case file
  string              op_name[$];
  string              op_code[$];
  logic [`LBC_AW-1:0] op_addr[$];
  logic [`LBC_DW-1:0] op_wdata[$];
  logic [`LBC_DW-1:0] op_exp[$];
  int wait_cycles = 0;
  int bad_lines = 0;
  int limit = 0;
  int cycles = 0;

  lbc_top lbc_top_i (
    .SYSCLK    (SYSCLK),
    .arst_n    (arst_n),
    .cpu_valid (cpu_valid),
    .cpu_req   (cpu_req),
    .ej_valid  (ej_valid),
    .ej_req    (ej_req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .halt_w    (halt_w)
  );

  lbc_checker lbc_checker_i (
    .SYSCLK    (SYSCLK),
    .arst_n    (arst_n),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .halt_w    (halt_w)
  );

  initial
  begin
    SYSCLK = 1'b0;
    forever #5 SYSCLK = ~SYSCLK;
  end

  function automatic logic op_known(input string op);
    return (op == "IF") || (op == "DR") || (op == "DRU") || (op == "DW") ||
           (op == "EJR") || (op == "EJW") || (op == "WAIT");
  endfunction

  task automatic read_cases();
    int fd;
    int rc;
    string line;
    string name;
    string op;
    logic [31:0] a, d, e;
    fd = $fopen("bench/lbc_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open case file bench/lbc_cases.txt");
      bad_lines++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if ((rc > 0) && (line.len() > 1) && (line.getc(0) != "#"))
        begin
          rc = $sscanf(line, "%s %s %h %h %h", name, op, a, d, e);
          if ((rc != 5) || !op_known(op))
          begin
            $display("Malformed case line: %s", line);
            bad_lines++;
          end
          else
          begin
            op_name.push_back(name);
            op_code.push_back(op);
            op_addr.push_back(a[`LBC_AW-1:0]);
            op_wdata.push_back(d);
            op_exp.push_back(e);
            if (op == "WAIT")
              wait_cycles += int'(a[`LBC_AW-1:0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // DW waits for buffer room, reads and debug wait for their class
  task automatic wait_ready(input logic is_dw, input lbc_src_e src);
    while (is_dw ? halt_w : (lbc_checker_i.outstanding(src) != 0))
    begin
      @(posedge SYSCLK);
      #1;
    end
  endtask

  task automatic drive_op(input int i);
    string op;
    logic is_dw, is_ej;
    lbc_src_e src;
    op    = op_code[i];
    is_dw = (op == "DW");
    is_ej = (op == "EJR") || (op == "EJW");
    src   = is_ej ? SRC_EJ : ((op == "IF") ? SRC_I : SRC_DR);
    @(posedge SYSCLK);
    #1;
    cpu_valid = 1'b0;
    ej_valid  = 1'b0;
    if (op == "WAIT")
      repeat (int'(op_addr[i])) @(posedge SYSCLK);
    else
    begin
      wait_ready(is_dw, src);
      if (is_ej)
      begin
        ej_req   = '{write: (op == "EJW"), addr: op_addr[i], wdata: op_wdata[i]};
        ej_valid = 1'b1;
      end
      else
      begin
        cpu_req = '{kind: is_dw ? DWRITE : ((src == SRC_I) ? IFETCH : DREAD),
                    uc: (op == "DRU"), addr: op_addr[i], wdata: op_wdata[i]};
        cpu_valid = 1'b1;
      end
      if (!is_dw)
        lbc_checker_i.expect_rsp(op_name[i], src, op_addr[i], op_exp[i]);
    end
  endtask

  initial
  begin
    arst_n    = 1'b0;
    cpu_valid = 1'b0;
    cpu_req   = '0;
    ej_valid  = 1'b0;
    ej_req    = '0;
    read_cases();
    limit = op_name.size() * (`LBC_BUS_LAT + 2) * (`LBC_WB_DEPTH + 3) + wait_cycles;
    repeat (RST_CYCLES) @(posedge SYSCLK);
    #1 arst_n = 1'b1;
    for (int i = 0; i < op_name.size(); i++)
      drive_op(i);
    @(posedge SYSCLK);
    #1;
    cpu_valid = 1'b0;
    ej_valid  = 1'b0;
    while (lbc_checker_i.remaining() != 0)
    begin
      @(posedge SYSCLK);
      #1;
    end
    repeat (2) @(posedge SYSCLK);
    lbc_checker_i.report_totals();
    if ((lbc_checker_i.errors == 0) && (bad_lines == 0) && (lbc_checker_i.passes > 0))
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Run limit counted from reset release
  initial
  begin
    wait (arst_n === 1'b1);
    while (cycles < limit)
    begin
      @(posedge SYSCLK);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d responses still missing",
             limit, lbc_checker_i.remaining());
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/lbc_cases.txt */
# name op addr wdata expect, all hex; WAIT gives its cycle count in the addr column
# op is IF, DR, DRU (uncached read), DW, EJR, EJW or WAIT; unused columns are 0
zero_if  IF   10 00000000 00000000
zero_dr  DR   11 00000000 00000000
zero_ej  EJR  12 00000000 00000000
hit_dw   DW   20 a1b2c3d4 00000000
hit_dr   DR   20 00000000 a1b2c3d4
bw0      DW   50 c0de0050 00000000
bw1      DW   51 c0de0051 00000000
bw2      DW   52 c0de0052 00000000
bw3      DW   53 c0de0053 00000000
bw4      DW   54 c0de0054 00000000
bw5      DW   55 c0de0055 00000000
bw6      DW   56 c0de0056 00000000
bw7      DW   57 c0de0057 00000000
trio_if  IF   50 00000000 c0de0050
trio_dr  DR   51 00000000 c0de0051
trio_ej  EJR  52 00000000 c0de0052
uw0      DW   30 30303030 00000000
uw1      DW   31 31313131 00000000
uw2      DW   32 32323232 00000000
uc_dr    DRU  53 00000000 c0de0053
rb30     DR   30 00000000 30303030
rb31     IF   31 00000000 31313131
rb32     EJR  32 00000000 32323232
rb54     DR   54 00000000 c0de0054
rb55     IF   55 00000000 c0de0055
rb56     EJR  56 00000000 c0de0056
rb57     DR   57 00000000 c0de0057
gap      WAIT 0a 00000000 00000000
ejw60    EJW  60 deadbeef deadbeef
ejr60    EJR  60 00000000 deadbeef
dr60     DR   60 00000000 deadbeef

/* verilog.f */
+incdir+design
design/lbc_pkg.sv
design/lbc_write_buf.sv
design/lbc_bus_engine.sv
design/lbc_cbus.sv
design/lbc_top.sv
bench/lbc_checker.sv
bench/lbc_tb.sv
